// File: src.f
logic/tlb_pkg.sv
logic/tlb_entry_array.sv
logic/tlb_match.sv
logic/tlb_dmw_check.sv
logic/tlb_translate_port.sv
logic/tlb_ctrl.sv
logic/tlb_top.sv
testbench/tb_tlb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the TLB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_tlb -o tb_tlb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/tb_tlb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
exit 1

// File: testbench/tb_tlb.sv
`timescale 1ns/1ps

module tb_tlb;
    import tlb_pkg::*;

    localparam int T1_LEN = 12;
    localparam int T2_LEN = 76;
    localparam int T3_LEN = 204;
    localparam int T4_LEN = 154;
    localparam int T5_LEN = 40;
    localparam int T6_LEN = 7 * 33 + 4;
    localparam int CYCLE_LIMIT = 8 + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + T6_LEN + 100;

    logic                   clk;
    logic                   rst_n;
    mmu_csr_t               csr;
    logic                   xlat_en_0;
    xlat_req_t              xlat_req_0;
    logic                   xlat_valid_0;
    xlat_rsp_t              xlat_rsp_0;
    logic                   xlat_en_1;
    xlat_req_t              xlat_req_1;
    logic                   xlat_valid_1;
    xlat_rsp_t              xlat_rsp_1;
    logic                   cmd_en;
    tlb_cmd_t               cmd;
    tlb_entry_t             rd_entry;
    logic                   srch_hit;
    logic [TLB_IDX_W-1:0]   srch_index;
    logic                   cmd_done;

    // reference model state
    tlb_entry_t             model [TLB_NUM];
    int                     fill_ptr = 0;
    int                     seed = 32'hb4339b80;

    // expectations computed at the drive edge and latched at the request edge
    xlat_rsp_t              exp_nxt_0;
    xlat_rsp_t              exp_nxt_1;
    xlat_rsp_t              exp_rsp_0;
    xlat_rsp_t              exp_rsp_1;
    tlb_entry_t             exp_rd_nxt;
    tlb_entry_t             exp_rd;
    logic                   exp_hit_nxt;
    logic                   exp_hit;
    logic [TLB_IDX_W-1:0]   exp_idx_nxt;
    logic [TLB_IDX_W-1:0]   exp_idx;
    logic                   en_q0 = 1'b0;
    logic                   en_q1 = 1'b0;
    logic                   done_q = 1'b0;
    logic                   rd_chk = 1'b0;
    logic                   srch_chk = 1'b0;
    int                     errors = 0;
    int                     err_mark = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     cycles = 0;

    tlb_top DUT (
        .clk (clk), .rst_n (rst_n), .csr (csr),
        .xlat_en_0 (xlat_en_0), .xlat_req_0 (xlat_req_0),
        .xlat_valid_0 (xlat_valid_0), .xlat_rsp_0 (xlat_rsp_0),
        .xlat_en_1 (xlat_en_1), .xlat_req_1 (xlat_req_1),
        .xlat_valid_1 (xlat_valid_1), .xlat_rsp_1 (xlat_rsp_1),
        .cmd_en (cmd_en), .cmd (cmd), .rd_entry (rd_entry),
        .srch_hit (srch_hit), .srch_index (srch_index), .cmd_done (cmd_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        en_q0    <= xlat_en_0;
        en_q1    <= xlat_en_1;
        done_q   <= cmd_en;
        rd_chk   <= cmd_en && (cmd.op == RD);
        srch_chk <= cmd_en && (cmd.op == SRCH);
        if (xlat_en_0) begin
            exp_rsp_0 <= exp_nxt_0;
        end
        if (xlat_en_1) begin
            exp_rsp_1 <= exp_nxt_1;
        end
        if (cmd_en) begin
            exp_rd  <= exp_rd_nxt;
            exp_hit <= exp_hit_nxt;
            exp_idx <= exp_idx_nxt;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not complete", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic report_fail(input string name, input logic [127:0] exp_val,
                               input logic [127:0] got_val);
        $display("Fail %0t %s expected %h got %h", $time, name, exp_val, got_val);
        errors++;
    endtask

    // only the code is compared on a refill where paddr and mat are undefined
    function automatic logic rsp_ok(xlat_rsp_t got, xlat_rsp_t want);
        return (got.excp == want.excp) && ((want.excp == TLBR) || (got == want));
    endfunction

    a_valid0: assert property (@(posedge clk) disable iff (!rst_n) xlat_valid_0 == en_q0)
        else report_fail("xlat_valid_0", 128'($sampled(en_q0)), 128'($sampled(xlat_valid_0)));
    a_valid1: assert property (@(posedge clk) disable iff (!rst_n) xlat_valid_1 == en_q1)
        else report_fail("xlat_valid_1", 128'($sampled(en_q1)), 128'($sampled(xlat_valid_1)));
    a_rsp0: assert property (@(posedge clk) disable iff (!rst_n)
        xlat_valid_0 |-> rsp_ok(xlat_rsp_0, exp_rsp_0))
        else report_fail("xlat_rsp_0", 128'($sampled(exp_rsp_0)), 128'($sampled(xlat_rsp_0)));
    a_rsp1: assert property (@(posedge clk) disable iff (!rst_n)
        xlat_valid_1 |-> rsp_ok(xlat_rsp_1, exp_rsp_1))
        else report_fail("xlat_rsp_1", 128'($sampled(exp_rsp_1)), 128'($sampled(xlat_rsp_1)));
    a_done: assert property (@(posedge clk) disable iff (!rst_n) cmd_done == done_q)
        else report_fail("cmd_done", 128'($sampled(done_q)), 128'($sampled(cmd_done)));
    a_rd: assert property (@(posedge clk) disable iff (!rst_n) rd_chk |-> rd_entry == exp_rd)
        else report_fail("rd_entry", 128'($sampled(exp_rd)), 128'($sampled(rd_entry)));
    a_hit: assert property (@(posedge clk) disable iff (!rst_n) srch_chk |-> srch_hit == exp_hit)
        else report_fail("srch_hit", 128'($sampled(exp_hit)), 128'($sampled(srch_hit)));
    a_idx: assert property (@(posedge clk) disable iff (!rst_n)
        srch_chk |-> srch_index == exp_idx)
        else report_fail("srch_index", 128'($sampled(exp_idx)), 128'($sampled(srch_index)));

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic va_match(tlb_entry_t t, logic [31:0] va);
        if (!t.e) return 1'b0;
        if (t.ps == PS_2M) return t.vpn2[18:8] == va[31:21];
        return t.vpn2 == va[31:13];
    endfunction

    // lowest matching index or -1 on a miss
    function automatic int find_hit(logic [31:0] va, logic [9:0] asid);
        for (int i = 0; i < TLB_NUM; i++) begin
            if (va_match(model[i], va) && (model[i].g || (model[i].asid == asid))) return i;
        end
        return -1;
    endfunction

    function automatic logic window_hit(dmw_cfg_t w, xlat_req_t r);
        return (r.vaddr[31:29] == w.vseg) && (((r.plv == 2'd0) && w.plv0) ||
                                             ((r.plv == 2'd3) && w.plv3));
    endfunction

    function automatic xlat_rsp_t model_xlat(xlat_req_t r, mmu_csr_t c);
        xlat_rsp_t   o;
        tlb_entry_t  t;
        tlb_page_t   pg;
        dmw_cfg_t    w;
        logic [31:0] mask;
        int          h;
        o.paddr = r.vaddr;
        o.mat   = c.da_mat;
        o.excp  = NONE;
        h = find_hit(r.vaddr, c.asid);
        if (c.da) return o;
        if (window_hit(c.dmw0, r) || window_hit(c.dmw1, r)) begin
            w = window_hit(c.dmw0, r) ? c.dmw0 : c.dmw1;
            o.paddr = {w.pseg, r.vaddr[28:0]};
            o.mat   = w.mat;
            return o;
        end
        if (h < 0) begin
            o.excp = TLBR;
            return o;
        end
        t = model[h];
        // odd page bit is the lowest bit above the page offset
        pg = r.vaddr[t.ps] ? t.page1 : t.page0;
        mask = (32'd1 << t.ps) - 32'd1;
        o.paddr = ({pg.pfn, 12'h000} & ~mask) | (r.vaddr & mask);
        o.mat = pg.mat;
        if (!pg.v) o.excp = (r.mem_type == FETCH) ? PIF : (r.mem_type == STORE) ? PIS : PIL;
        else if (r.plv > pg.plv) o.excp = PPI;
        else if ((r.mem_type == STORE) && !pg.d) o.excp = PME;
        return o;
    endfunction

    task automatic model_cmd(input tlb_cmd_t c);
        int   h;
        logic sel;
        logic va;
        logic as;
        h = find_hit(c.key_vaddr, c.key_asid);
        exp_hit_nxt = (h >= 0);
        exp_idx_nxt = (h >= 0) ? TLB_IDX_W'(h) : '0;
        exp_rd_nxt  = model[c.index];
        case (c.op)
            WR: model[c.index] = c.entry;
            FILL: begin
                model[fill_ptr] = c.entry;
                fill_ptr = (fill_ptr + 1) % TLB_NUM;
            end
            INV: begin
                for (int i = 0; i < TLB_NUM; i++) begin
                    va = va_match(model[i], c.key_vaddr);
                    as = (model[i].asid == c.key_asid);
                    case (c.inv_op)
                        3'd0, 3'd1: sel = 1'b1;
                        3'd2:       sel = model[i].g;
                        3'd3:       sel = !model[i].g;
                        3'd4:       sel = !model[i].g && as;
                        3'd5:       sel = !model[i].g && as && va;
                        3'd6:       sel = (model[i].g || as) && va;
                        default:    sel = 1'b0;
                    endcase
                    if (sel) model[i].e = 1'b0;
                end
            end
            default: ;
        endcase
    endtask

    function automatic tlb_page_t rand_page();
        logic [31:0] r;
        tlb_page_t   p;
        r = rnd();
        p.pfn = r[19:0];
        p.mat = r[21:20];
        p.plv = r[23:22];
        p.d   = r[24];
        p.v   = r[25] | r[26];
        return p;
    endfunction

    // small vpn and asid pools so that matches overlap
    function automatic tlb_entry_t rand_entry();
        logic [31:0] r;
        tlb_entry_t  t;
        r = rnd();
        t.e     = (r[13:11] != 3'd0);
        t.vpn2  = {r[2:0], 8'h00, r[5:3], 5'h00};
        t.asid  = {8'h00, r[7:6]};
        t.g     = r[8] & r[9];
        t.ps    = r[10] ? PS_2M : PS_4K;
        t.page0 = rand_page();
        t.page1 = rand_page();
        return t;
    endfunction

    // mostly addresses inside a model entry and sometimes anywhere
    function automatic logic [31:0] rand_vaddr();
        logic [31:0] r;
        logic [31:0] s;
        tlb_entry_t  t;
        r = rnd();
        s = rnd();
        t = model[r[3:0]];
        if (r[5:4] == 2'd0) return s;
        if (t.ps == PS_2M) return {t.vpn2[18:8], s[20:0]};
        return {t.vpn2, s[12:0]};
    endfunction

    function automatic mmu_csr_t tlb_csr();
        logic [31:0] r;
        mmu_csr_t    c;
        r = rnd();
        c = mmu_csr_t'(r);
        c.da = 1'b0;
        c.asid = {8'h00, r[1:0]};
        c.dmw0.plv0 = 1'b0;
        c.dmw0.plv3 = 1'b0;
        c.dmw1.plv0 = 1'b0;
        c.dmw1.plv3 = 1'b0;
        return c;
    endfunction

    // windows aimed at the request so dmw0, dmw1 and tlb hits overlap
    function automatic mmu_csr_t window_csr(logic [31:0] va);
        logic [31:0] r;
        logic [31:0] s;
        mmu_csr_t    c;
        r = rnd();
        s = rnd();
        c.da = (r[1:0] == 2'd0);
        c.da_mat = r[3:2];
        c.asid = {8'h00, r[5:4]};
        c.dmw0 = '{plv0: r[6], plv3: r[7], mat: r[9:8],
                   vseg: r[10] ? va[31:29] : s[2:0], pseg: s[5:3]};
        c.dmw1 = '{plv0: r[11], plv3: r[12], mat: r[14:13],
                   vseg: r[15] ? va[31:29] : s[8:6], pseg: s[11:9]};
        return c;
    endfunction

    function automatic xlat_req_t make_req(logic [31:0] va);
        logic [31:0] r;
        xlat_req_t   q;
        r = rnd();
        q.vaddr = va;
        q.plv = r[1:0];
        q.mem_type = mem_type_e'((r[3:2] == 2'd3) ? 2'd0 : r[3:2]);
        return q;
    endfunction

    function automatic tlb_cmd_t make_cmd(tlb_op_e op, int idx, int inv, logic [31:0] kva,
                                          logic [9:0] kas, tlb_entry_t ent);
        tlb_cmd_t c;
        c.op = op;
        c.index = TLB_IDX_W'(idx);
        c.inv_op = 3'(inv);
        c.key_vaddr = kva;
        c.key_asid = kas;
        c.entry = ent;
        return c;
    endfunction

    // drive one cycle right after a falling edge
    task automatic issue(input logic en0, input logic [31:0] va0, input logic en1,
                         input logic [31:0] va1, input logic cen, input tlb_cmd_t c);
        xlat_en_0  = en0;
        xlat_req_0 = make_req(va0);
        xlat_en_1  = en1;
        xlat_req_1 = make_req(va1);
        exp_nxt_0  = model_xlat(xlat_req_0, csr);
        exp_nxt_1  = model_xlat(xlat_req_1, csr);
        cmd_en = cen;
        cmd = c;
        if (cen) model_cmd(c);
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            issue(1'b0, 32'h0, 1'b0, 32'h0, 1'b0, make_cmd(NOP, 0, 0, 32'h0, 10'h0, '0));
        end
    endtask

    task automatic finish_test(input string name);
        idle(2);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed, %0d errors", name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    initial begin
        logic [31:0] r;
        rst_n = 1'b0;
        csr = '0;
        xlat_en_0 = 1'b0;
        xlat_req_0 = '0;
        xlat_en_1 = 1'b0;
        xlat_req_1 = '0;
        cmd_en = 1'b0;
        cmd = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        idle(3);
        csr = tlb_csr();
        issue(1'b1, rand_vaddr(), 1'b1, rand_vaddr(), 1'b0, make_cmd(NOP, 0, 0, 0, 0, '0));
        finish_test("reset_state");

        for (int i = 0; i < TLB_NUM; i++) begin
            issue(1'b0, 32'h0, 1'b0, 32'h0, 1'b1, make_cmd(WR, i, 0, 0, 0, rand_entry()));
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            issue(1'b0, 32'h0, 1'b0, 32'h0, 1'b1, make_cmd(RD, i, 0, 0, 0, '0));
        end
        for (int i = 0; i < 40; i++) begin
            r = rnd();
            issue(1'b0, 32'h0, 1'b0, 32'h0, 1'b1,
                  make_cmd(SRCH, 0, 0, rand_vaddr(), {8'h00, r[1:0]}, '0));
        end
        finish_test("write_read_search");

        // back to back on both ports with writes racing the lookups
        for (int i = 0; i < 200; i++) begin
            r = rnd();
            csr = tlb_csr();
            issue(1'b1, rand_vaddr(), 1'b1, rand_vaddr(), (i % 8) == 7,
                  make_cmd(WR, int'(r[3:0]), 0, 0, 0, rand_entry()));
        end
        finish_test("random_translate");

        for (int i = 0; i < 150; i++) begin
            r = rand_vaddr();
            csr = window_csr(r);
            issue(1'b1, r, 1'b1, rand_vaddr(), 1'b0, make_cmd(NOP, 0, 0, 0, 0, '0));
        end
        finish_test("direct_and_windows");

        for (int i = 0; i < 20; i++) begin
            issue(1'b0, 32'h0, 1'b0, 32'h0, 1'b1, make_cmd(FILL, 0, 0, 0, 0, rand_entry()));
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            issue(1'b0, 32'h0, 1'b0, 32'h0, 1'b1, make_cmd(RD, i, 0, 0, 0, '0));
        end
        finish_test("fill_pointer");

        for (int op = 0; op < 7; op++) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                issue(1'b0, 32'h0, 1'b0, 32'h0, 1'b1, make_cmd(WR, i, 0, 0, 0, rand_entry()));
            end
            r = rnd();
            issue(1'b0, 32'h0, 1'b0, 32'h0, 1'b1,
                  make_cmd(INV, 0, op, rand_vaddr(), {8'h00, r[1:0]}, '0));
            for (int i = 0; i < TLB_NUM; i++) begin
                csr = tlb_csr();
                issue(1'b1, rand_vaddr(), 1'b1, rand_vaddr(), 1'b1,
                      make_cmd(RD, i, 0, 0, 0, '0));
            end
        end
        finish_test("invalidate");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: logic/tlb_top.sv
`timescale 1ns/1ps

module tlb_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  tlb_pkg::mmu_csr_t               csr,

    // fetch port
    input  logic                            xlat_en_0,
    input  tlb_pkg::xlat_req_t              xlat_req_0,
    output logic                            xlat_valid_0,
    output tlb_pkg::xlat_rsp_t              xlat_rsp_0,

    // load/store port
    input  logic                            xlat_en_1,
    input  tlb_pkg::xlat_req_t              xlat_req_1,
    output logic                            xlat_valid_1,
    output tlb_pkg::xlat_rsp_t              xlat_rsp_1,

    // management
    input  logic                            cmd_en,
    input  tlb_pkg::tlb_cmd_t               cmd,
    output tlb_pkg::tlb_entry_t             rd_entry,
    output logic                            srch_hit,
    output logic [tlb_pkg::TLB_IDX_W-1:0]   srch_index,
    output logic                            cmd_done
);
    import tlb_pkg::*;

    tlb_entry_t [TLB_NUM-1:0]   entries;
    logic                       wr_en;
    logic [TLB_IDX_W-1:0]       wr_index;
    tlb_entry_t                 wr_entry;
    logic [TLB_NUM-1:0]         inv_mask;

    tlb_entry_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_entry   (wr_entry),
        .inv_mask   (inv_mask),
        .entries    (entries)
    );

    tlb_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_en     (cmd_en),
        .cmd        (cmd),
        .entries    (entries),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_entry   (wr_entry),
        .inv_mask   (inv_mask),
        .rd_entry   (rd_entry),
        .srch_hit   (srch_hit),
        .srch_index (srch_index),
        .cmd_done   (cmd_done)
    );

    tlb_translate_port u_port0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr        (csr),
        .entries    (entries),
        .xlat_en    (xlat_en_0),
        .xlat_req   (xlat_req_0),
        .xlat_valid (xlat_valid_0),
        .xlat_rsp   (xlat_rsp_0)
    );

    tlb_translate_port u_port1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr        (csr),
        .entries    (entries),
        .xlat_en    (xlat_en_1),
        .xlat_req   (xlat_req_1),
        .xlat_valid (xlat_valid_1),
        .xlat_rsp   (xlat_rsp_1)
    );

endmodule

// File: logic/tlb_ctrl.sv
`timescale 1ns/1ps

module tlb_ctrl (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        cmd_en,
    input  tlb_pkg::tlb_cmd_t                           cmd,
    input  tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0]  entries,
    output logic                                        wr_en,
    output logic [tlb_pkg::TLB_IDX_W-1:0]               wr_index,
    output tlb_pkg::tlb_entry_t                         wr_entry,
    output logic [tlb_pkg::TLB_NUM-1:0]                 inv_mask,
    output tlb_pkg::tlb_entry_t                         rd_entry,
    output logic                                        srch_hit,
    output logic [tlb_pkg::TLB_IDX_W-1:0]               srch_index,
    output logic                                        cmd_done
);
    import tlb_pkg::*;

    logic [TLB_NUM-1:0]     va_hit;
    logic [TLB_NUM-1:0]     asid_hit;
    logic [TLB_NUM-1:0]     g_vec;
    logic [TLB_NUM-1:0]     srch_vec;
    logic [TLB_IDX_W-1:0]   srch_idx_nxt;
    logic [TLB_IDX_W-1:0]   fill_ptr;
    logic                   is_rd;
    logic                   is_wr;
    logic                   is_fill;
    logic                   is_srch;
    logic                   is_inv;

    tlb_match u_match (
        .entries    (entries),
        .vaddr      (cmd.key_vaddr),
        .asid       (cmd.key_asid),
        .va_hit     (va_hit),
        .asid_hit   (asid_hit)
    );

    assign is_rd   = cmd_en && (cmd.op == RD);
    assign is_wr   = cmd_en && (cmd.op == WR);
    assign is_fill = cmd_en && (cmd.op == FILL);
    assign is_srch = cmd_en && (cmd.op == SRCH);
    assign is_inv  = cmd_en && (cmd.op == INV);

    assign wr_en    = is_wr || is_fill;
    assign wr_index = is_fill ? fill_ptr : cmd.index;
    assign wr_entry = cmd.entry;

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            g_vec[i] = entries[i].g;
        end
    end

    assign srch_vec = va_hit & (g_vec | asid_hit);

    always_comb begin
        srch_idx_nxt = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (srch_vec[i]) begin
                srch_idx_nxt = TLB_IDX_W'(i);
            end
        end
    end

    // invalidate selection by op
    always_comb begin
        inv_mask = '0;
        if (is_inv) begin
            case (cmd.inv_op)
                3'd0, 3'd1: inv_mask = '1;
                3'd2:       inv_mask = g_vec;
                3'd3:       inv_mask = ~g_vec;
                3'd4:       inv_mask = ~g_vec & asid_hit;
                3'd5:       inv_mask = ~g_vec & asid_hit & va_hit;
                3'd6:       inv_mask = (g_vec | asid_hit) & va_hit;
                default:    inv_mask = '0;
            endcase
        end
    end

    // round robin fill pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_ptr <= '0;
            srch_hit <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= cmd_en;
            if (is_fill) begin
                fill_ptr <= fill_ptr + TLB_IDX_W'(1);
            end
            if (is_srch) begin
                srch_hit <= |srch_vec;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_rd) begin
            rd_entry <= entries[cmd.index];
        end
        if (is_srch) begin
            srch_index <= srch_idx_nxt;
        end
    end

endmodule

// File: logic/tlb_translate_port.sv
`timescale 1ns/1ps

module tlb_translate_port (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  tlb_pkg::mmu_csr_t                           csr,
    input  tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0]  entries,
    input  logic                                        xlat_en,
    input  tlb_pkg::xlat_req_t                          xlat_req,
    output logic                                        xlat_valid,
    output tlb_pkg::xlat_rsp_t                          xlat_rsp
);
    import tlb_pkg::*;

    typedef struct packed {
        xlat_req_t      req;
        logic           da;
        logic [1:0]     da_mat;
        logic           dmw_hit;
        logic [31:0]    dmw_paddr;
        logic [1:0]     dmw_mat;
        logic           tlb_hit;
        tlb_entry_t     entry;
    } stage_t;

    logic [TLB_NUM-1:0]     va_hit;
    logic [TLB_NUM-1:0]     asid_hit;
    logic [TLB_NUM-1:0]     hit_vec;
    logic                   dmw0_hit;
    logic                   dmw1_hit;
    logic [31:0]            dmw0_paddr;
    logic [31:0]            dmw1_paddr;
    logic [1:0]             dmw0_mat;
    logic [1:0]             dmw1_mat;
    stage_t                 stage_d;
    stage_t                 stage_q;
    tlb_page_t              page;
    logic                   odd;

    tlb_match u_match (
        .entries    (entries),
        .vaddr      (xlat_req.vaddr),
        .asid       (csr.asid),
        .va_hit     (va_hit),
        .asid_hit   (asid_hit)
    );

    tlb_dmw_check u_dmw0 (
        .dmw    (csr.dmw0),
        .vaddr  (xlat_req.vaddr),
        .plv    (xlat_req.plv),
        .hit    (dmw0_hit),
        .paddr  (dmw0_paddr),
        .mat    (dmw0_mat)
    );

    tlb_dmw_check u_dmw1 (
        .dmw    (csr.dmw1),
        .vaddr  (xlat_req.vaddr),
        .plv    (xlat_req.plv),
        .hit    (dmw1_hit),
        .paddr  (dmw1_paddr),
        .mat    (dmw1_mat)
    );

    assign hit_vec = va_hit & (asid_hit | global_bits(entries));

    function automatic logic [TLB_NUM-1:0] global_bits(
        input tlb_entry_t [TLB_NUM-1:0] ent
    );
        logic [TLB_NUM-1:0] g;
        for (int i = 0; i < TLB_NUM; i++) begin
            g[i] = ent[i].g;
        end
        return g;
    endfunction

    // dmw0 ahead of dmw1 and the lowest tlb index wins
    always_comb begin
        stage_d.req       = xlat_req;
        stage_d.da        = csr.da;
        stage_d.da_mat    = csr.da_mat;
        stage_d.dmw_hit   = dmw0_hit || dmw1_hit;
        stage_d.dmw_paddr = dmw0_hit ? dmw0_paddr : dmw1_paddr;
        stage_d.dmw_mat   = dmw0_hit ? dmw0_mat : dmw1_mat;
        stage_d.tlb_hit   = |hit_vec;
        stage_d.entry     = entries[0];
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                stage_d.entry = entries[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xlat_en) begin
            stage_q <= stage_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xlat_valid <= 1'b0;
        end else begin
            xlat_valid <= xlat_en;
        end
    end

    // odd page bit sits just above the page offset
    assign odd  = (stage_q.entry.ps == PS_2M) ? stage_q.req.vaddr[21] : stage_q.req.vaddr[12];
    assign page = odd ? stage_q.entry.page1 : stage_q.entry.page0;

    always_comb begin
        xlat_rsp.paddr = stage_q.req.vaddr;
        xlat_rsp.mat   = stage_q.da_mat;
        xlat_rsp.excp  = NONE;
        if (stage_q.da) begin
            xlat_rsp.mat = stage_q.da_mat;
        end else if (stage_q.dmw_hit) begin
            xlat_rsp.paddr = stage_q.dmw_paddr;
            xlat_rsp.mat   = stage_q.dmw_mat;
        end else begin
            if (stage_q.entry.ps == PS_2M) begin
                xlat_rsp.paddr = {page.pfn[19:9], stage_q.req.vaddr[20:0]};
            end else begin
                xlat_rsp.paddr = {page.pfn, stage_q.req.vaddr[11:0]};
            end
            xlat_rsp.mat = page.mat;
            if (!stage_q.tlb_hit) begin
                xlat_rsp.excp = TLBR;
            end else if (!page.v) begin
                case (stage_q.req.mem_type)
                    FETCH:   xlat_rsp.excp = PIF;
                    STORE:   xlat_rsp.excp = PIS;
                    default: xlat_rsp.excp = PIL;
                endcase
            end else if (stage_q.req.plv > page.plv) begin
                xlat_rsp.excp = PPI;
            end else if ((stage_q.req.mem_type == STORE) && !page.d) begin
                xlat_rsp.excp = PME;
            end
        end
    end

endmodule

// File: logic/tlb_dmw_check.sv
`timescale 1ns/1ps

module tlb_dmw_check (
    input  tlb_pkg::dmw_cfg_t   dmw,
    input  logic [31:0]         vaddr,
    input  logic [1:0]          plv,
    output logic                hit,
    output logic [31:0]         paddr,
    output logic [1:0]          mat
);

    logic seg_match;
    logic plv_ok;

    assign seg_match = (vaddr[31:29] == dmw.vseg);

    // only plv 0 and 3 have enables
    assign plv_ok = ((plv == 2'd0) && dmw.plv0) || ((plv == 2'd3) && dmw.plv3);

    assign hit   = seg_match && plv_ok;
    assign paddr = {dmw.pseg, vaddr[28:0]};
    assign mat   = dmw.mat;

endmodule

// File: logic/tlb_match.sv
`timescale 1ns/1ps

module tlb_match (
    input  tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0]  entries,
    input  logic [31:0]                                 vaddr,
    input  logic [9:0]                                  asid,
    output logic [tlb_pkg::TLB_NUM-1:0]                 va_hit,
    output logic [tlb_pkg::TLB_NUM-1:0]                 asid_hit
);
    import tlb_pkg::*;

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            // 2M pages drop vaddr[20:13] from the compare
            if (entries[i].ps == PS_2M) begin
                va_hit[i] = entries[i].e && (entries[i].vpn2[18:8] == vaddr[31:21]);
            end else begin
                va_hit[i] = entries[i].e && (entries[i].vpn2 == vaddr[31:13]);
            end
            asid_hit[i] = (entries[i].asid == asid);
        end
    end

endmodule

// File: logic/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        wr_en,
    input  logic [tlb_pkg::TLB_IDX_W-1:0]               wr_index,
    input  tlb_pkg::tlb_entry_t                         wr_entry,
    input  logic [tlb_pkg::TLB_NUM-1:0]                 inv_mask,
    output tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0]  entries
);
    import tlb_pkg::*;

    // exist bits held apart from the entry body
    logic [TLB_NUM-1:0]             exist_q;
    tlb_entry_t [TLB_NUM-1:0]       body_q;
    logic [TLB_NUM-1:0]             wr_sel;

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            wr_sel[i] = wr_en && (wr_index == TLB_IDX_W'(i));
        end
    end

    // write beats invalidate on the same entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exist_q <= '0;
        end else begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (wr_sel[i]) begin
                    exist_q[i] <= wr_entry.e;
                end else if (inv_mask[i]) begin
                    exist_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_NUM; i++) begin
            if (wr_sel[i]) begin
                body_q[i] <= wr_entry;
            end
        end
    end

    // flattened view for all lookups
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            entries[i]   = body_q[i];
            entries[i].e = exist_q[i];
        end
    end

endmodule

// File: logic/tlb_pkg.sv
package tlb_pkg;

    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;

    // the only page sizes supported
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_2M = 6'd21;

    // one half of an even/odd pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vpn2;
        logic [9:0]  asid;
        logic [5:0]  ps;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        LOAD  = 2'd0,
        STORE = 2'd1,
        FETCH = 2'd2
    } mem_type_e;

    typedef enum logic [2:0] {
        NONE = 3'd0,
        TLBR = 3'd1,
        PIL  = 3'd2,
        PIS  = 3'd3,
        PIF  = 3'd4,
        PME  = 3'd5,
        PPI  = 3'd6
    } excp_e;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_cfg_t;

    typedef struct packed {
        logic       da;
        logic [1:0] da_mat;
        logic [9:0] asid;
        dmw_cfg_t   dmw0;
        dmw_cfg_t   dmw1;
    } mmu_csr_t;

    typedef struct packed {
        logic [31:0] vaddr;
        logic [1:0]  plv;
        mem_type_e   mem_type;
    } xlat_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic [1:0]  mat;
        excp_e       excp;
    } xlat_rsp_t;

    typedef enum logic [2:0] {
        NOP  = 3'd0,
        RD   = 3'd1,
        WR   = 3'd2,
        FILL = 3'd3,
        SRCH = 3'd4,
        INV  = 3'd5
    } tlb_op_e;

    typedef struct packed {
        tlb_op_e                op;
        logic [TLB_IDX_W-1:0]   index;
        logic [2:0]             inv_op;
        logic [31:0]            key_vaddr;
        logic [9:0]             key_asid;
        tlb_entry_t             entry;
    } tlb_cmd_t;

endpackage
